// ==== vrf_req_pkg.sv ====
/*
 * Shared definitions for the VRF operand requester: data widths, the
 * instruction count, element widths, fetch commands, writeback payloads
 * and the master numbering used by the bank arbiters.
 */
package vrf_req_pkg;

  // Vector instructions in flight
  localparam int unsigned NrVInsn = 8;
  typedef logic [$clog2(NrVInsn)-1:0] vid_t;

  // One VRF word and its byte enables
  typedef logic [63:0] elen_t;
  typedef logic [7:0]  strb_t;

  // Word address, bank in the low bits and row above them
  localparam int unsigned VaddrWidth = 10;
  typedef logic [VaddrWidth-1:0] vaddr_t;

  typedef enum logic [1:0] {EW8, EW16, EW32, EW64} vew_e;

  typedef logic [9:0] vlen_t;

  typedef enum logic {QueueA, QueueB} opqueue_e;

  // Read command for one operand queue
  typedef struct packed {
    vid_t               id;
    logic [4:0]         vs;
    vlen_t              vl;
    vew_e               eew;
    logic [NrVInsn-1:0] hazard;
  } fetch_cmd_t;

  // Result coming back from a functional unit
  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } wb_result_t;

  // Masters 0 and 1 are high priority, 2 and 3 low priority
  typedef enum logic [1:0] {MstQueueA, MstAlu, MstQueueB, MstLdu} master_e;
  localparam int unsigned NrMasters = 4;

endpackage

// ==== vrf_port_if.sv ====
`timescale 1ns/1ps
/*
 * VRF port of one master. The master holds req and its payload until gnt,
 * which the bank arbiter returns in the same cycle.
 */
interface vrf_port_if;

  import vrf_req_pkg::*;

  logic     req;
  vaddr_t   addr;
  logic     wen;
  elen_t    wdata;
  strb_t    be;
  opqueue_e tgt;
  logic     gnt;

  modport master (
    output req, addr, wen, wdata, be, tgt,
    input  gnt
  );

  modport arbiter (
    input  req, addr, wen, wdata, be, tgt,
    output gnt
  );

endinterface

// ==== result_skid_reg.sv ====
`timescale 1ns/1ps
/*
 * One-entry valid/ready register. Takes a new payload when empty or when
 * the held payload leaves in the same cycle.
 */
module result_skid_reg #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  logic full_q;
  T     data_q;
  logic load;

  // Empty, or the held entry drains this cycle
  assign ready_o = ~full_q | ready_i;
  assign load    = valid_i & ready_o;

  assign valid_o = full_q;
  assign data_o  = data_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (load) begin
      full_q <= 1'b1;
    end else if (ready_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      data_q <= data_i;
    end
  end

endmodule

// ==== operand_fetch_fsm.sv ====
`timescale 1ns/1ps
/*
 * Operand requester for one queue. Walks the 64-bit words of a source
 * register in order and requests each one from the banked VRF, holding off
 * while a hazard on an older instruction has no fresh result.
 */
module operand_fetch_fsm #(
  parameter int unsigned NrBanks     = 4,
  parameter int unsigned WordsPerReg = 16
) (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  vrf_req_pkg::opqueue_e                       queue_i,
  input  vrf_req_pkg::fetch_cmd_t                     cmd_i,
  input  logic                                        cmd_valid_i,
  output logic                                        cmd_ready_o,
  input  logic                                        queue_ready_i,
  input  logic [vrf_req_pkg::NrVInsn-1:0]
               [vrf_req_pkg::NrVInsn-1:0]             hazard_table_i,
  input  logic [vrf_req_pkg::NrVInsn-1:0]             written_i,
  output logic                                        issued_o,
  vrf_port_if.master                                  vrf
);

  import vrf_req_pkg::*;

  typedef enum logic {IDLE, REQUESTING} state_e;

  state_e             state_d, state_q;
  vid_t               id_d, id_q;
  vaddr_t             addr_d, addr_q;
  vlen_t              len_d, len_q;
  vew_e               eew_d, eew_q;
  logic [NrVInsn-1:0] hazard_d, hazard_q;

  logic  stall;
  logic  word_gnt;
  vlen_t elems_per_word;

  // Registers are laid out in whole bank rows
  if (WordsPerReg % NrBanks != 0) begin : gen_layout_check
    $error("WordsPerReg must be a multiple of NrBanks");
  end

  // Wait for every older writer we depend on to produce a result
  assign stall          = |(hazard_q & ~written_i);
  assign elems_per_word = vlen_t'(4'd8 >> eew_q);
  assign word_gnt       = vrf.req & vrf.gnt;

  ////////////////////////////////////////////////////////////////////
  // VRF read port
  ////////////////////////////////////////////////////////////////////

  assign vrf.req   = (state_q == REQUESTING) & queue_ready_i & ~stall;
  assign vrf.addr  = addr_q;
  assign vrf.wen   = 1'b0;
  assign vrf.wdata = '0;
  assign vrf.be    = '0;
  assign vrf.tgt   = queue_i;
  assign issued_o  = word_gnt;

  always_comb begin
    state_d     = state_q;
    id_d        = id_q;
    addr_d      = addr_q;
    len_d       = len_q;
    eew_d       = eew_q;
    hazard_d    = hazard_q;
    cmd_ready_o = 1'b0;

    // Next word, the count floors at zero on a partial last word
    if (state_q == REQUESTING && word_gnt) begin
      addr_d = addr_q + 1'b1;
      len_d  = (len_q > elems_per_word) ? len_q - elems_per_word : '0;
      if (len_d == '0) begin
        state_d = IDLE;
      end
    end

    // Take a command when idle or in the cycle of the last grant
    if (state_d == IDLE && cmd_valid_i) begin
      cmd_ready_o = 1'b1;
      id_d        = cmd_i.id;
      addr_d      = vaddr_t'(cmd_i.vs * WordsPerReg);
      len_d       = cmd_i.vl;
      eew_d       = cmd_i.eew;
      hazard_d    = cmd_i.hazard;
      state_d     = (cmd_i.vl == '0) ? IDLE : REQUESTING;
    end

    // Drop hazards that the sequencer has already retired
    hazard_d &= hazard_table_i[id_d];
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      len_q    <= '0;
      hazard_q <= '0;
    end else begin
      state_q  <= state_d;
      len_q    <= len_d;
      hazard_q <= hazard_d;
    end
  end

  always_ff @(posedge clk_i) begin
    id_q   <= id_d;
    addr_q <= addr_d;
    eew_q  <= eew_d;
  end

endmodule

// ==== vrf_bank_arbiter.sv ====
`timescale 1ns/1ps
/*
 * Per-bank VRF arbitration. Queue A and the ALU share round robin at high
 * priority, queue B and the load unit at low priority, and any high-priority
 * request masks the low group. The winner drives the bank port.
 */
module vrf_bank_arbiter #(
  parameter int unsigned NrBanks = 4
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  vrf_port_if.arbiter                         mst [vrf_req_pkg::NrMasters],
  output logic                  [NrBanks-1:0] vrf_req_o,
  output vrf_req_pkg::vaddr_t   [NrBanks-1:0] vrf_addr_o,
  output logic                  [NrBanks-1:0] vrf_wen_o,
  output vrf_req_pkg::elen_t    [NrBanks-1:0] vrf_wdata_o,
  output vrf_req_pkg::strb_t    [NrBanks-1:0] vrf_be_o,
  output vrf_req_pkg::opqueue_e [NrBanks-1:0] vrf_tgt_o
);

  import vrf_req_pkg::*;

  localparam int unsigned BankBits = $clog2(NrBanks);

  logic     [NrMasters-1:0]              mst_req;
  logic     [NrMasters-1:0]              mst_wen;
  logic     [NrMasters-1:0]              mst_gnt;
  vaddr_t   [NrMasters-1:0]              mst_addr;
  elen_t    [NrMasters-1:0]              mst_wdata;
  strb_t    [NrMasters-1:0]              mst_be;
  opqueue_e [NrMasters-1:0]              mst_tgt;
  logic     [NrBanks-1:0][NrMasters-1:0] bank_gnt;

  // Two-way round robin, ptr selects the second member on a tie
  function automatic logic [1:0] rr_pick(input logic [1:0] req, input logic ptr);
    if (&req) begin
      return ptr ? 2'b10 : 2'b01;
    end
    return req;
  endfunction

  for (genvar m = 0; m < NrMasters; m++) begin : gen_master
    assign mst_req[m]   = mst[m].req;
    assign mst_addr[m]  = mst[m].addr;
    assign mst_wen[m]   = mst[m].wen;
    assign mst_wdata[m] = mst[m].wdata;
    assign mst_be[m]    = mst[m].be;
    assign mst_tgt[m]   = mst[m].tgt;
    assign mst[m].gnt   = mst_gnt[m];
  end

  ////////////////////////////////////////////////////////////////////
  // Arbitration per bank
  ////////////////////////////////////////////////////////////////////

  for (genvar b = 0; b < NrBanks; b++) begin : gen_bank
    logic [NrMasters-1:0] bank_req;
    logic [1:0]           hp_req, lp_req;
    logic [1:0]           hp_gnt, lp_gnt;
    logic                 hp_ptr_q, lp_ptr_q;

    always_comb begin
      for (int m = 0; m < NrMasters; m++) begin
        bank_req[m] = mst_req[m] && (mst_addr[m][BankBits-1:0] == BankBits'(b));
      end
    end

    assign hp_req = {bank_req[MstAlu], bank_req[MstQueueA]};
    assign lp_req = {bank_req[MstLdu], bank_req[MstQueueB]};
    assign hp_gnt = rr_pick(hp_req, hp_ptr_q);
    assign lp_gnt = (|hp_req) ? 2'b00 : rr_pick(lp_req, lp_ptr_q);

    // Bit order follows the master numbering
    assign bank_gnt[b] = {lp_gnt, hp_gnt};

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        hp_ptr_q <= 1'b0;
        lp_ptr_q <= 1'b0;
      end else begin
        if (&hp_req) begin
          hp_ptr_q <= ~hp_ptr_q;
        end
        if (&lp_req && !(|hp_req)) begin
          lp_ptr_q <= ~lp_ptr_q;
        end
      end
    end
  end

  // Winner drives the bank, the VRF acknowledges at once
  always_comb begin
    mst_gnt = '0;
    for (int b = 0; b < NrBanks; b++) begin
      vrf_req_o[b]   = 1'b0;
      vrf_addr_o[b]  = '0;
      vrf_wen_o[b]   = 1'b0;
      vrf_wdata_o[b] = '0;
      vrf_be_o[b]    = '0;
      vrf_tgt_o[b]   = QueueA;
      for (int m = 0; m < NrMasters; m++) begin
        if (bank_gnt[b][m]) begin
          mst_gnt[m]     = 1'b1;
          vrf_req_o[b]   = 1'b1;
          vrf_addr_o[b]  = mst_addr[m] >> BankBits;
          vrf_wen_o[b]   = mst_wen[m];
          vrf_wdata_o[b] = mst_wdata[m];
          vrf_be_o[b]    = mst_be[m];
          vrf_tgt_o[b]   = mst_tgt[m];
        end
      end
    end
  end

endmodule

// ==== operand_requester_top.sv ====
`timescale 1ns/1ps
/*
 * VRF operand requester for one lane: two operand fetchers, ALU and load
 * unit writeback, the result-written tracker and the per-bank arbiters.
 */
module operand_requester_top #(
  parameter int unsigned NrBanks     = 4,
  parameter int unsigned WordsPerReg = 16
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic [vrf_req_pkg::NrVInsn-1:0]
               [vrf_req_pkg::NrVInsn-1:0]         global_hazard_table_i,
  // Fetch commands, one per queue
  input  vrf_req_pkg::fetch_cmd_t [1:0]           fetch_cmd_i,
  input  logic                    [1:0]           fetch_valid_i,
  output logic                    [1:0]           fetch_ready_o,
  input  logic                    [1:0]           operand_queue_ready_i,
  output logic                    [1:0]           operand_issued_o,
  // ALU result
  input  logic                                    alu_result_req_i,
  input  vrf_req_pkg::vid_t                       alu_result_id_i,
  input  vrf_req_pkg::vaddr_t                     alu_result_addr_i,
  input  vrf_req_pkg::elen_t                      alu_result_wdata_i,
  input  vrf_req_pkg::strb_t                      alu_result_be_i,
  output logic                                    alu_result_gnt_o,
  // Load unit result
  input  logic                                    ldu_result_req_i,
  input  vrf_req_pkg::vid_t                       ldu_result_id_i,
  input  vrf_req_pkg::vaddr_t                     ldu_result_addr_i,
  input  vrf_req_pkg::elen_t                      ldu_result_wdata_i,
  input  vrf_req_pkg::strb_t                      ldu_result_be_i,
  output logic                                    ldu_result_gnt_o,
  output logic                                    ldu_result_final_gnt_o,
  // VRF banks
  output logic                    [NrBanks-1:0]   vrf_req_o,
  output vrf_req_pkg::vaddr_t     [NrBanks-1:0]   vrf_addr_o,
  output logic                    [NrBanks-1:0]   vrf_wen_o,
  output vrf_req_pkg::elen_t      [NrBanks-1:0]   vrf_wdata_o,
  output vrf_req_pkg::strb_t      [NrBanks-1:0]   vrf_be_o,
  output vrf_req_pkg::opqueue_e   [NrBanks-1:0]   vrf_tgt_o
);

  import vrf_req_pkg::*;

  vrf_port_if port_if [NrMasters] ();

  logic [NrVInsn-1:0] written_d, written_q;
  wb_result_t         ldu_in, ldu_out;
  logic               ldu_req, ldu_gnt;

  ////////////////////////////////////////////////////////////////////
  // Operand fetch
  ////////////////////////////////////////////////////////////////////

  for (genvar q = 0; q < 2; q++) begin : gen_fetch
    localparam int unsigned Mst = (q == 0) ? MstQueueA : MstQueueB;

    operand_fetch_fsm #(
      .NrBanks     (NrBanks),
      .WordsPerReg (WordsPerReg)
    ) i_fetch (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .queue_i        (opqueue_e'(q)),
      .cmd_i          (fetch_cmd_i[q]),
      .cmd_valid_i    (fetch_valid_i[q]),
      .cmd_ready_o    (fetch_ready_o[q]),
      .queue_ready_i  (operand_queue_ready_i[q]),
      .hazard_table_i (global_hazard_table_i),
      .written_i      (written_q),
      .issued_o       (operand_issued_o[q]),
      .vrf            (port_if[Mst])
    );
  end

  ////////////////////////////////////////////////////////////////////
  // Writeback masters
  ////////////////////////////////////////////////////////////////////

  // ALU writes straight from its ports
  assign port_if[MstAlu].req   = alu_result_req_i;
  assign port_if[MstAlu].addr  = alu_result_addr_i;
  assign port_if[MstAlu].wen   = 1'b1;
  assign port_if[MstAlu].wdata = alu_result_wdata_i;
  assign port_if[MstAlu].be    = alu_result_be_i;
  assign port_if[MstAlu].tgt   = QueueA;
  assign alu_result_gnt_o      = port_if[MstAlu].gnt;

  assign ldu_in = '{
    id:    ldu_result_id_i,
    addr:  ldu_result_addr_i,
    wdata: ldu_result_wdata_i,
    be:    ldu_result_be_i
  };

  result_skid_reg #(
    .T (wb_result_t)
  ) i_ldu_skid (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (ldu_result_req_i),
    .ready_o (ldu_result_gnt_o),
    .data_i  (ldu_in),
    .valid_o (ldu_req),
    .ready_i (ldu_gnt),
    .data_o  (ldu_out)
  );

  assign port_if[MstLdu].req   = ldu_req;
  assign port_if[MstLdu].addr  = ldu_out.addr;
  assign port_if[MstLdu].wen   = 1'b1;
  assign port_if[MstLdu].wdata = ldu_out.wdata;
  assign port_if[MstLdu].be    = ldu_out.be;
  assign port_if[MstLdu].tgt   = QueueA;
  assign ldu_gnt               = port_if[MstLdu].gnt;

  // Results written this cycle, seen by the fetchers one cycle later
  always_comb begin
    written_d = '0;
    if (alu_result_gnt_o) begin
      written_d[alu_result_id_i] = 1'b1;
    end
    if (ldu_gnt) begin
      written_d[ldu_out.id] = 1'b1;
    end
  end

  // Final grant only once the load data is really in the VRF
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      written_q              <= '0;
      ldu_result_final_gnt_o <= 1'b0;
    end else begin
      written_q              <= written_d;
      ldu_result_final_gnt_o <= ldu_gnt;
    end
  end

  vrf_bank_arbiter #(
    .NrBanks (NrBanks)
  ) i_arbiter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .mst         (port_if),
    .vrf_req_o   (vrf_req_o),
    .vrf_addr_o  (vrf_addr_o),
    .vrf_wen_o   (vrf_wen_o),
    .vrf_wdata_o (vrf_wdata_o),
    .vrf_be_o    (vrf_be_o),
    .vrf_tgt_o   (vrf_tgt_o)
  );

endmodule

// ==== operand_requester_sva.sv ====
`timescale 1ns/1ps
/*
 * Concurrent checks on the operand requester: one grant per bank, fetch
 * addresses held while stalled, load unit final grant timing and quiet
 * VRF outputs in reset.
 */
module operand_requester_sva #(
  parameter int unsigned NrBanks = 4
) (
  input logic                                          clk_i,
  input logic                                          rst_ni,
  input logic [NrBanks-1:0][vrf_req_pkg::NrMasters-1:0] bank_gnt_i,
  input logic [1:0]                                    fetch_busy_i,
  input logic [1:0]                                    fetch_stall_i,
  input logic [1:0]                                    queue_ready_i,
  input vrf_req_pkg::vaddr_t [1:0]                     fetch_addr_i,
  input logic [1:0]                                    issued_i,
  input logic                                          ldu_gnt_i,
  input logic                                          final_gnt_i,
  input logic [NrBanks-1:0]                            vrf_req_i,
  input logic [NrBanks-1:0]                            vrf_wen_i
);

  for (genvar b = 0; b < NrBanks; b++) begin : gen_bank
    assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(bank_gnt_i[b]))
      else $error("Bank %0d granted to more than one master", b);
  end

  // Hazard stall or queue back-pressure
  for (genvar q = 0; q < 2; q++) begin : gen_queue
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      fetch_busy_i[q] && (fetch_stall_i[q] || !queue_ready_i[q])
      |=> $stable(fetch_addr_i[q]))
      else $error("Queue %0d address moved while stalled", q);
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) ldu_gnt_i |=> final_gnt_i)
    else $error("Load unit final grant missing one cycle after its write");

  assert property (@(posedge clk_i) disable iff (!rst_ni) final_gnt_i |-> $past(ldu_gnt_i))
    else $error("Load unit final grant without a write in the previous cycle");

  assert property (@(posedge clk_i)
    !rst_ni |-> (vrf_req_i == '0 && vrf_wen_i == '0 && issued_i == '0 && !final_gnt_i))
    else $error("VRF outputs active during reset");

endmodule

bind operand_requester_top operand_requester_sva #(
  .NrBanks (NrBanks)
) i_sva (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .bank_gnt_i    (i_arbiter.bank_gnt),
  .fetch_busy_i  ({gen_fetch[1].i_fetch.state_q, gen_fetch[0].i_fetch.state_q}),
  .fetch_stall_i ({gen_fetch[1].i_fetch.stall, gen_fetch[0].i_fetch.stall}),
  .queue_ready_i (operand_queue_ready_i),
  .fetch_addr_i  ({gen_fetch[1].i_fetch.addr_q, gen_fetch[0].i_fetch.addr_q}),
  .issued_i      (operand_issued_o),
  .ldu_gnt_i     (ldu_gnt),
  .final_gnt_i   (ldu_result_final_gnt_o),
  .vrf_req_i     (vrf_req_o),
  .vrf_wen_i     (vrf_wen_o)
);

// ==== tb_operand_requester.sv ====
`timescale 1ns/1ps
/*
 * Directed testbench for the VRF operand requester. Covers sequential
 * reads, zero length, back-pressure, hazard stall, write priority, the
 * load unit path and round robin on one bank.
 */
module tb_operand_requester;

  import vrf_req_pkg::*;

  localparam int NrBanks     = 4;
  localparam int WordsPerReg = 16;
  localparam int Timeout     = 50;

  logic                              clk_i;
  logic                              rst_ni;
  logic [NrVInsn-1:0][NrVInsn-1:0]   hazard_table;
  fetch_cmd_t [1:0]                  fetch_cmd;
  logic [1:0]                        fetch_valid, fetch_ready;
  logic [1:0]                        queue_ready, issued;
  logic                              alu_req, alu_gnt;
  vid_t                              alu_id;
  vaddr_t                            alu_addr;
  elen_t                             alu_wdata;
  strb_t                             alu_be;
  logic                              ldu_req, ldu_gnt, ldu_final_gnt;
  vid_t                              ldu_id;
  vaddr_t                            ldu_addr;
  elen_t                             ldu_wdata;
  strb_t                             ldu_be;
  logic [NrBanks-1:0]                vrf_req, vrf_wen;
  vaddr_t [NrBanks-1:0]              vrf_addr;
  elen_t [NrBanks-1:0]               vrf_wdata;
  strb_t [NrBanks-1:0]               vrf_be;
  opqueue_e [NrBanks-1:0]            vrf_tgt;
  integer                            seed;

  operand_requester_top #(
    .NrBanks     (NrBanks),
    .WordsPerReg (WordsPerReg)
  ) dut (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .global_hazard_table_i  (hazard_table),
    .fetch_cmd_i            (fetch_cmd),
    .fetch_valid_i          (fetch_valid),
    .fetch_ready_o          (fetch_ready),
    .operand_queue_ready_i  (queue_ready),
    .operand_issued_o       (issued),
    .alu_result_req_i       (alu_req),
    .alu_result_id_i        (alu_id),
    .alu_result_addr_i      (alu_addr),
    .alu_result_wdata_i     (alu_wdata),
    .alu_result_be_i        (alu_be),
    .alu_result_gnt_o       (alu_gnt),
    .ldu_result_req_i       (ldu_req),
    .ldu_result_id_i        (ldu_id),
    .ldu_result_addr_i      (ldu_addr),
    .ldu_result_wdata_i     (ldu_wdata),
    .ldu_result_be_i        (ldu_be),
    .ldu_result_gnt_o       (ldu_gnt),
    .ldu_result_final_gnt_o (ldu_final_gnt),
    .vrf_req_o              (vrf_req),
    .vrf_addr_o             (vrf_addr),
    .vrf_wen_o              (vrf_wen),
    .vrf_wdata_o            (vrf_wdata),
    .vrf_be_o               (vrf_be),
    .vrf_tgt_o              (vrf_tgt)
  );

  always #50 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////
  // Reporting and expected values
  ////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string msg);
    $display("MISMATCH at %0t ns: %s", $time, msg);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out at %0t ns while waiting for %s", $time, what);
    $display("Regression failed");
    $fatal(1);
  endtask

  // Words to read rounded up to whole 64-bit words
  function automatic int word_count(input int vl, input vew_e eew);
    int bytes;
    case (eew)
      EW8:     bytes = 1;
      EW16:    bytes = 2;
      EW32:    bytes = 4;
      default: bytes = 8;
    endcase
    return (vl * bytes + 7) / 8;
  endfunction

  function automatic fetch_cmd_t make_cmd(input vid_t id, input logic [4:0] vs,
                                          input vlen_t vl, input vew_e eew,
                                          input logic [NrVInsn-1:0] hazard);
    fetch_cmd_t cmd;
    cmd.id     = id;
    cmd.vs     = vs;
    cmd.vl     = vl;
    cmd.eew    = eew;
    cmd.hazard = hazard;
    return cmd;
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Drivers and monitors
  ////////////////////////////////////////////////////////////////////

  task automatic send_cmd(input int q, input fetch_cmd_t cmd);
    int cycles;
    cycles = 0;
    @(posedge clk_i);
    fetch_cmd[q]   <= cmd;
    fetch_valid[q] <= 1'b1;
    do begin
      @(negedge clk_i);
      cycles++;
      if (cycles > Timeout) begin
        report_timeout($sformatf("queue %0d to accept a command", q));
      end
    end while (!fetch_ready[q]);
    @(posedge clk_i);
    fetch_valid[q] <= 1'b0;
  endtask

  // One issue pulse per word with its read on the right bank
  task automatic expect_reads(input int q, input int start_addr, input int nwords);
    int cycles;
    int bank;
    int row;
    for (int n = 0; n < nwords; n++) begin
      cycles = 0;
      do begin
        @(negedge clk_i);
        cycles++;
        if (cycles > Timeout) begin
          report_timeout($sformatf("queue %0d to issue word %0d", q, n));
        end
      end while (!issued[q]);
      bank = (start_addr + n) % NrBanks;
      row  = (start_addr + n) / NrBanks;
      assert (vrf_req[bank] && vrf_addr[bank] == row)
        else report_mismatch($sformatf("queue %0d word %0d not read at bank %0d row %0d",
                                       q, n, bank, row));
      assert (!vrf_wen[bank] && vrf_tgt[bank] == opqueue_e'(q))
        else report_mismatch($sformatf("queue %0d word %0d has wrong wen or target", q, n));
    end
  endtask

  task automatic expect_no_requests(input int cycles);
    repeat (cycles) begin
      @(negedge clk_i);
      assert (vrf_req == '0 && issued == '0)
        else report_mismatch("unexpected VRF request");
    end
  endtask

  task automatic check_write(input int bank, input int row, input elen_t data,
                             input strb_t be);
    assert (vrf_req[bank] && vrf_wen[bank] && vrf_addr[bank] == row)
      else report_mismatch($sformatf("no write on bank %0d row %0d", bank, row));
    assert (vrf_wdata[bank] == data && vrf_be[bank] == be)
      else report_mismatch($sformatf("bank %0d write data %h be %h, expected %h %h",
                                     bank, vrf_wdata[bank], vrf_be[bank], data, be));
  endtask

  task automatic alu_write(input vid_t id, input vaddr_t addr);
    elen_t data;
    strb_t be;
    int    cycles;
    data   = {$random(seed), $random(seed)};
    be     = $random(seed);
    cycles = 0;
    @(posedge clk_i);
    alu_req   <= 1'b1;
    alu_id    <= id;
    alu_addr  <= addr;
    alu_wdata <= data;
    alu_be    <= be;
    do begin
      @(negedge clk_i);
      cycles++;
      if (cycles > Timeout) begin
        report_timeout("the ALU write grant");
      end
    end while (!alu_gnt);
    check_write(addr % NrBanks, addr / NrBanks, data, be);
    @(posedge clk_i);
    alu_req <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////

  task automatic sequential_read();
    send_cmd(0, make_cmd(3'd0, 5'd2, 10'd12, EW16, '0));
    expect_reads(0, 2 * WordsPerReg, word_count(12, EW16));
    expect_no_requests(5);
  endtask

  task automatic zero_length_and_backpressure();
    send_cmd(0, make_cmd(3'd1, 5'd4, 10'd0, EW32, '0));
    expect_no_requests(5);
    @(posedge clk_i);
    queue_ready[1] <= 1'b0;
    send_cmd(1, make_cmd(3'd2, 5'd5, 10'd8, EW64, '0));
    expect_no_requests(20);
    @(posedge clk_i);
    queue_ready[1] <= 1'b1;
    expect_reads(1, 5 * WordsPerReg, word_count(8, EW64));
  endtask

  // Bit 5 stays in the table row of id 2 until the first read is seen
  task automatic hazard_stall();
    @(posedge clk_i);
    hazard_table[2] <= 8'h20;
    send_cmd(1, make_cmd(3'd2, 5'd1, 10'd4, EW64, 8'h20));
    expect_no_requests(10);
    alu_write(3'd5, 10'd7);
    expect_reads(1, WordsPerReg, 1);
    @(posedge clk_i);
    hazard_table[2] <= '0;
    expect_reads(1, WordsPerReg + 1, 3);
  endtask

  task automatic write_priority();
    elen_t data;
    strb_t be;
    data = {$random(seed), $random(seed)};
    be   = $random(seed);
    send_cmd(1, make_cmd(3'd3, 5'd3, 10'd2, EW64, '0));
    expect_reads(1, 3 * WordsPerReg, 1);
    // Second read goes to bank 1 where the ALU joins it
    @(posedge clk_i);
    alu_req   <= 1'b1;
    alu_id    <= 3'd4;
    alu_addr  <= 10'd5;
    alu_wdata <= data;
    alu_be    <= be;
    @(negedge clk_i);
    assert (alu_gnt && !issued[1])
      else report_mismatch("ALU write did not win bank 1 over queue B");
    check_write(1, 1, data, be);
    @(posedge clk_i);
    alu_req <= 1'b0;
    expect_reads(1, 3 * WordsPerReg + 1, 1);
  endtask

  // The ALU holds bank 2 so the accepted result waits in the skid register
  task automatic load_unit_path();
    elen_t data;
    strb_t be;
    int    cycles;
    data   = {$random(seed), $random(seed)};
    be     = $random(seed);
    cycles = 0;
    @(posedge clk_i);
    alu_req   <= 1'b1;
    alu_id    <= 3'd0;
    alu_addr  <= 10'd6;
    ldu_req   <= 1'b1;
    ldu_id    <= 3'd6;
    ldu_addr  <= 10'd10;
    ldu_wdata <= data;
    ldu_be    <= be;
    do begin
      @(negedge clk_i);
      cycles++;
      if (cycles > Timeout) begin
        report_timeout("the load unit to accept a result");
      end
    end while (!ldu_gnt);
    @(posedge clk_i);
    ldu_req <= 1'b0;
    @(negedge clk_i);
    assert (!ldu_gnt && alu_gnt && !ldu_final_gnt)
      else report_mismatch("load unit accepted a result while full and blocked on bank 2");
    @(posedge clk_i);
    alu_req <= 1'b0;
    cycles  = 0;
    do begin
      @(negedge clk_i);
      cycles++;
      if (cycles > Timeout) begin
        report_timeout("the load unit write on bank 2");
      end
    end while (!(vrf_req[2] && vrf_wen[2]));
    check_write(2, 2, data, be);
    assert (!ldu_final_gnt) else report_mismatch("final grant in the write cycle");
    @(negedge clk_i);
    assert (ldu_final_gnt) else report_mismatch("final grant missing after the write");
    @(negedge clk_i);
    assert (!ldu_final_gnt) else report_mismatch("final grant longer than one cycle");
  endtask

  // Back-to-back one-word reads on bank 0 against a steady ALU write
  task automatic round_robin();
    logic last_alu;
    @(posedge clk_i);
    fetch_cmd[0]   <= make_cmd(3'd1, 5'd6, 10'd1, EW64, '0);
    fetch_valid[0] <= 1'b1;
    alu_req        <= 1'b1;
    alu_id         <= 3'd0;
    alu_addr       <= 10'd4;
    alu_wdata      <= {$random(seed), $random(seed)};
    alu_be         <= 8'hff;
    repeat (2) @(negedge clk_i);
    last_alu = alu_gnt;
    for (int i = 0; i < 12; i++) begin
      @(negedge clk_i);
      assert (issued[0] ^ alu_gnt)
        else report_mismatch("bank 0 not granted to exactly one of queue A and ALU");
      assert (alu_gnt != last_alu)
        else report_mismatch("queue A and ALU not both served in two grant cycles");
      last_alu = alu_gnt;
    end
    @(posedge clk_i);
    fetch_valid[0] <= 1'b0;
    alu_req        <= 1'b0;
  endtask

  initial begin
    seed         = 38;
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    hazard_table = '0;
    fetch_cmd    = '0;
    fetch_valid  = '0;
    queue_ready  = 2'b11;
    alu_req      = 1'b0;
    alu_id       = '0;
    alu_addr     = '0;
    alu_wdata    = '0;
    alu_be       = '0;
    ldu_req      = 1'b0;
    ldu_id       = '0;
    ldu_addr     = '0;
    ldu_wdata    = '0;
    ldu_be       = '0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    assert (vrf_req == '0 && fetch_ready == '0 && issued == '0 && !ldu_final_gnt)
      else report_mismatch("outputs not idle after reset");
    sequential_read();
    zero_length_and_backpressure();
    hazard_stall();
    write_priority();
    load_unit_path();
    round_robin();
    repeat (4) @(posedge clk_i);
    $display("Regression passed");
    $finish;
  end

endmodule

// ==== operand_requester_top.f ====
vrf_req_pkg.sv
vrf_port_if.sv
result_skid_reg.sv
operand_fetch_fsm.sv
vrf_bank_arbiter.sv
operand_requester_top.sv
operand_requester_sva.sv
tb_operand_requester.sv
